//--- hw/rw_mgr_cfg.svh
/* Build-time sizes and the register map of the read/write manager block.
   Included by the packages and by every module that needs a width or an offset */
`ifndef RW_MGR_CFG_SVH
`define RW_MGR_CFG_SVH

// RAM geometry
`define RW_MGR_DATA_WIDTH 32
`define RW_MGR_NUM_WORDS 4
`define RW_MGR_ADDR_WIDTH 2

// AXI4-Lite byte address width
`define RW_MGR_AXI_ADDR_WIDTH 8

// One scan request moves exactly one word through the chain
`define RW_MGR_SCAN_LEN `RW_MGR_DATA_WIDTH

// Register map, RAM words sit at 0x00 to 0x0C
`define RW_MGR_REG_RAM_BASE 8'h00
`define RW_MGR_REG_SCAN 8'h10
`define RW_MGR_REG_STATUS 8'h14

`endif

//--- hw/rw_mgr_data_pkg.sv
/* Vector types for the RAM contents, word addresses and scan bookkeeping.
   Imported by the RAM, the scan controller, the slave and the bus package */
`include "rw_mgr_cfg.svh"

package rw_mgr_data_pkg;

  // One RAM word
  typedef logic [`RW_MGR_DATA_WIDTH-1:0] rw_data_t;

  // Word address inside the RAM
  typedef logic [`RW_MGR_ADDR_WIDTH-1:0] rw_addr_t;

  // All words back to back, word j in slice j so word 0 holds the low bits
  typedef logic [`RW_MGR_DATA_WIDTH*`RW_MGR_NUM_WORDS-1:0] rw_chain_t;

  // Counts shifted bits, one spare bit above the scan length
  typedef logic [$clog2(`RW_MGR_SCAN_LEN):0] rw_bitcnt_t;

endpackage

//--- hw/rw_mgr_bus_pkg.sv
/* AXI4-Lite channel structs, the RAM access port and the FSM state encodings.
   Shared by the slave, the scan controller, the RAM and the top level */
`include "rw_mgr_cfg.svh"

package rw_mgr_bus_pkg;
  import rw_mgr_data_pkg::*;

  typedef logic [`RW_MGR_AXI_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

  // Address channels, same layout for write and read
  typedef struct packed {
    axil_addr_t addr;
    logic       valid;
  } axil_aw_t;

  typedef struct packed {
    axil_addr_t addr;
    logic       valid;
  } axil_ar_t;

  typedef struct packed {
    rw_data_t data;
    logic     valid;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
    logic       valid;
  } axil_b_t;

  typedef struct packed {
    rw_data_t   data;
    axil_resp_t resp;
    logic       valid;
  } axil_r_t;

  // Ready of every channel, each side drives its own fields
  typedef struct packed {
    logic awready;
    logic wready;
    logic arready;
    logic bready;
    logic rready;
  } axil_ready_t;

  // Random access port into the RAM
  typedef struct packed {
    logic     wren;
    rw_addr_t wraddr;
    rw_data_t data;
    rw_addr_t rdaddr;
  } ram_port_t;

  typedef enum logic [2:0] {
    SLV_IDLE,
    SLV_WR_RESP,
    SLV_RD_WAIT,
    SLV_RD_RESP,
    SLV_SCAN_WAIT
  } slave_state_e;

  typedef enum logic {
    SCAN_IDLE,
    SCAN_SHIFT
  } scan_state_e;

endpackage

//--- hw/rw_mgr_ram_csr.sv
/* Four-word RAM that doubles as one serial scan chain.
   Random access while shift_en is low, one left shift per cycle while it is high */
`timescale 1ns/1ps
`include "rw_mgr_cfg.svh"

module rw_mgr_ram_csr
  import rw_mgr_data_pkg::*, rw_mgr_bus_pkg::*;
(
  input  logic      int_clk,
  input  logic      reset,
  input  ram_port_t ram,
  input  logic      shift_en,
  input  logic      shift_din,
  output rw_data_t  q,
  output logic      shift_dout
);

  localparam int DW      = `RW_MGR_DATA_WIDTH;
  localparam int CHAIN_W = `RW_MGR_DATA_WIDTH * `RW_MGR_NUM_WORDS;

  // Whole storage kept as one vector so the shift is a plain concatenation
  rw_chain_t all_data;

  always_ff @(posedge int_clk) begin
    if (reset) begin
      all_data <= '0;
    end else if (shift_en) begin
      // New bit enters at the bottom of word 0
      all_data <= {all_data[CHAIN_W-2:0], shift_din};
    end else if (ram.wren) begin
      all_data[ram.wraddr*DW +: DW] <= ram.data;
    end
  end

  // Registered read, q shows the addressed word one cycle later
  always_ff @(posedge int_clk) begin
    q <= all_data[ram.rdaddr*DW +: DW];
  end

  // Top bit of word 3 is the serial output
  assign shift_dout = all_data[CHAIN_W-1];

  // Storage only moves on a shift or a RAM write
  chain_hold_a: assert property (
    @(posedge int_clk) disable iff (reset)
    (!shift_en && !ram.wren) |=> $stable(all_data)
  ) else $error("RAM contents changed without a shift or a write");

  // Scan controller and slave never drive the RAM at the same time
  no_shift_during_write_a: assert property (
    @(posedge int_clk) disable iff (reset)
    !(shift_en && ram.wren)
  ) else $error("shift_en and wren high in the same cycle");

endmodule

//--- hw/rw_mgr_scan_ctrl.sv
/* Turns one scan request word into a burst of shift cycles on the RAM chain.
   The bits pushed out of the chain are collected into scan_capture */
`timescale 1ns/1ps
`include "rw_mgr_cfg.svh"

module rw_mgr_scan_ctrl
  import rw_mgr_data_pkg::*, rw_mgr_bus_pkg::*;
(
  input  logic     int_clk,
  input  logic     reset,
  input  logic     scan_req,
  input  rw_data_t scan_word,
  input  logic     shift_dout,
  output logic     shift_en,
  output logic     shift_din,
  output logic     scan_busy,
  output logic     scan_done,
  output rw_data_t scan_capture
);

  localparam int DW = `RW_MGR_DATA_WIDTH;
  localparam rw_bitcnt_t LAST_BIT = rw_bitcnt_t'(`RW_MGR_SCAN_LEN - 1);

  scan_state_e state;
  rw_bitcnt_t  bit_cnt;
  rw_data_t    shift_reg;

  assign shift_en  = (state == SCAN_SHIFT);
  assign scan_busy = (state == SCAN_SHIFT);
  // MSB of the request word goes into the chain first
  assign shift_din = shift_reg[DW-1];

  always_ff @(posedge int_clk) begin
    if (reset) begin
      state        <= SCAN_IDLE;
      bit_cnt      <= '0;
      scan_done    <= 1'b0;
      scan_capture <= '0;
    end else begin
      scan_done <= 1'b0;
      case (state)
        SCAN_IDLE: begin
          if (scan_req) begin
            state   <= SCAN_SHIFT;
            bit_cnt <= '0;
          end
        end
        SCAN_SHIFT: begin
          // Old word 3 arrives MSB first and ends up in bit order
          scan_capture <= {scan_capture[DW-2:0], shift_dout};
          bit_cnt      <= bit_cnt + 1'b1;
          if (bit_cnt == LAST_BIT) begin
            state     <= SCAN_IDLE;
            scan_done <= 1'b1;
          end
        end
        default: state <= SCAN_IDLE;
      endcase
    end
  end

  always_ff @(posedge int_clk) begin
    if (state == SCAN_IDLE && scan_req) begin
      shift_reg <= scan_word;
    end else if (state == SCAN_SHIFT) begin
      shift_reg <= shift_reg << 1;
    end
  end

  // The slave waits for scan_done, so a new request never overlaps a burst
  no_req_while_busy_a: assert property (
    @(posedge int_clk) disable iff (reset)
    scan_req |-> !scan_busy
  ) else $error("scan_req while a scan is still running");

endmodule

//--- hw/rw_mgr_axil_slave.sv
/* AXI4-Lite register slave for the RAM words, the scan register and the status word.
   Serves one transaction at a time, writes win over reads */
`timescale 1ns/1ps
`include "rw_mgr_cfg.svh"

module rw_mgr_axil_slave
  import rw_mgr_data_pkg::*, rw_mgr_bus_pkg::*;
(
  input  logic        int_clk,
  input  logic        reset,
  input  axil_aw_t    aw,
  input  axil_w_t     w,
  input  axil_ar_t    ar,
  input  axil_ready_t ready_in,
  output axil_b_t     b,
  output axil_r_t     r,
  output axil_ready_t ready_out,
  output ram_port_t   ram,
  input  rw_data_t    q,
  output logic        scan_req,
  output rw_data_t    scan_word,
  input  logic        scan_busy,
  input  logic        scan_done,
  input  rw_data_t    scan_capture
);

  localparam axil_addr_t RAM_END =
    axil_addr_t'(`RW_MGR_REG_RAM_BASE + 4 * `RW_MGR_NUM_WORDS);

  function automatic logic in_ram(input axil_addr_t addr);
    return (addr >= `RW_MGR_REG_RAM_BASE) && (addr < RAM_END) && (addr[1:0] == 2'b00);
  endfunction

  function automatic rw_addr_t word_addr(input axil_addr_t addr);
    return rw_addr_t'((addr - `RW_MGR_REG_RAM_BASE) >> 2);
  endfunction

  slave_state_e state;
  logic         wr_pending;
  logic         wr_hs;
  logic         rd_hs;
  logic         wr_ram;
  logic         wr_scan;
  logic         wr_status;
  // Read target, latched at the address handshake
  logic         rd_ram;
  logic         rd_scan;
  logic         rd_status;
  rw_data_t     status_word;

  assign wr_pending = aw.valid || w.valid;
  assign wr_hs      = (state == SLV_IDLE) && aw.valid && w.valid;
  assign rd_hs      = (state == SLV_IDLE) && ar.valid && !wr_pending;

  assign wr_ram    = in_ram(aw.addr);
  assign wr_scan   = (aw.addr == `RW_MGR_REG_SCAN);
  assign wr_status = (aw.addr == `RW_MGR_REG_STATUS);

  assign ready_out.awready = wr_hs;
  assign ready_out.wready  = wr_hs;
  assign ready_out.arready = rd_hs;
  // Response readies belong to the master
  assign ready_out.bready  = 1'b0;
  assign ready_out.rready  = 1'b0;

  // Word is stored on the handshake edge itself
  assign ram.wren   = wr_hs && wr_ram;
  assign ram.wraddr = word_addr(aw.addr);
  assign ram.data   = w.data;
  // q is registered on the ar handshake edge
  assign ram.rdaddr = word_addr(ar.addr);

  assign scan_req  = wr_hs && wr_scan;
  assign scan_word = w.data;

  assign status_word = {{(`RW_MGR_DATA_WIDTH-1){1'b0}}, scan_busy};

  always_ff @(posedge int_clk) begin
    if (rd_hs) begin
      rd_ram    <= in_ram(ar.addr);
      rd_scan   <= (ar.addr == `RW_MGR_REG_SCAN);
      rd_status <= (ar.addr == `RW_MGR_REG_STATUS);
    end
  end

  always_ff @(posedge int_clk) begin
    if (reset) begin
      state <= SLV_IDLE;
      b     <= '0;
      r     <= '0;
    end else begin
      case (state)
        SLV_IDLE: begin
          if (wr_hs) begin
            if (wr_scan) begin
              state <= SLV_SCAN_WAIT;
            end else begin
              // Status is read-only, a write there is accepted and ignored
              b.valid <= 1'b1;
              b.resp  <= (wr_ram || wr_status) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
              state   <= SLV_WR_RESP;
            end
          end else if (rd_hs) begin
            state <= SLV_RD_WAIT;
          end
        end
        SLV_SCAN_WAIT: begin
          if (scan_done) begin
            b.valid <= 1'b1;
            b.resp  <= AXIL_RESP_OKAY;
            state   <= SLV_WR_RESP;
          end
        end
        SLV_WR_RESP: begin
          if (ready_in.bready) begin
            b.valid <= 1'b0;
            state   <= SLV_IDLE;
          end
        end
        SLV_RD_WAIT: begin
          r.valid <= 1'b1;
          r.resp  <= AXIL_RESP_OKAY;
          if (rd_ram) begin
            r.data <= q;
          end else if (rd_scan) begin
            r.data <= scan_capture;
          end else if (rd_status) begin
            r.data <= status_word;
          end else begin
            r.data <= '0;
            r.resp <= AXIL_RESP_SLVERR;
          end
          state <= SLV_RD_RESP;
        end
        SLV_RD_RESP: begin
          if (ready_in.rready) begin
            r.valid <= 1'b0;
            state   <= SLV_IDLE;
          end
        end
        default: state <= SLV_IDLE;
      endcase
    end
  end

  // Write response holds under back-pressure
  bvalid_hold_a: assert property (
    @(posedge int_clk) disable iff (reset)
    (b.valid && !ready_in.bready) |=> b.valid
  ) else $error("bvalid dropped before bready");

endmodule

//--- hw/rw_mgr_top.sv
/* Top level of the read/write manager memory block.
   Joins the AXI4-Lite slave, the scan controller and the RAM chain */
`timescale 1ns/1ps

module rw_mgr_top
  import rw_mgr_data_pkg::*, rw_mgr_bus_pkg::*;
(
  input  logic        int_clk,
  input  logic        reset,
  input  axil_aw_t    aw,
  input  axil_w_t     w,
  input  axil_ar_t    ar,
  input  axil_ready_t ready_in,
  output axil_b_t     b,
  output axil_r_t     r,
  output axil_ready_t ready_out
);

  ram_port_t ram;
  rw_data_t  q;
  rw_data_t  scan_word;
  rw_data_t  scan_capture;
  logic      scan_req;
  logic      scan_busy;
  logic      scan_done;
  logic      shift_en;
  logic      shift_din;
  logic      shift_dout;

  rw_mgr_axil_slave u_axil_slave (
    .int_clk      (int_clk),
    .reset        (reset),
    .aw           (aw),
    .w            (w),
    .ar           (ar),
    .ready_in     (ready_in),
    .b            (b),
    .r            (r),
    .ready_out    (ready_out),
    .ram          (ram),
    .q            (q),
    .scan_req     (scan_req),
    .scan_word    (scan_word),
    .scan_busy    (scan_busy),
    .scan_done    (scan_done),
    .scan_capture (scan_capture)
  );

  rw_mgr_scan_ctrl u_scan_ctrl (
    .int_clk      (int_clk),
    .reset        (reset),
    .scan_req     (scan_req),
    .scan_word    (scan_word),
    .shift_dout   (shift_dout),
    .shift_en     (shift_en),
    .shift_din    (shift_din),
    .scan_busy    (scan_busy),
    .scan_done    (scan_done),
    .scan_capture (scan_capture)
  );

  rw_mgr_ram_csr u_ram_csr (
    .int_clk    (int_clk),
    .reset      (reset),
    .ram        (ram),
    .shift_en   (shift_en),
    .shift_din  (shift_din),
    .q          (q),
    .shift_dout (shift_dout)
  );

endmodule

//--- verif/rw_mgr_tb.sv
/* Self-checking testbench for the read/write manager block.
   Drives AXI4-Lite traffic with random ready delays and checks it against a word model */
`timescale 1ns/1ps
`include "rw_mgr_cfg.svh"

module rw_mgr_tb
  import rw_mgr_data_pkg::*, rw_mgr_bus_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int N_RANDOM   = 200;
  // Directed phases stay well below this count
  localparam int N_DIRECTED = 100;
  localparam int NUM_TXNS   = N_RANDOM + N_DIRECTED;
  localparam int NWORDS     = `RW_MGR_NUM_WORDS;

  logic        int_clk;
  logic        reset;
  axil_aw_t    aw;
  axil_w_t     w;
  axil_ar_t    ar;
  axil_ready_t ready_in;
  axil_b_t     b;
  axil_r_t     r;
  axil_ready_t ready_out;

  // Reference contents and the last word pushed out by a scan
  rw_data_t model_mem [NWORDS];
  rw_data_t model_cap;

  rw_mgr_top u_rw_mgr_top (
    .int_clk   (int_clk),
    .reset     (reset),
    .aw        (aw),
    .w         (w),
    .ar        (ar),
    .ready_in  (ready_in),
    .b         (b),
    .r         (r),
    .ready_out (ready_out)
  );

  always #(CLK_PERIOD / 2) int_clk = ~int_clk;

  function automatic axil_addr_t ram_addr(input int idx);
    return axil_addr_t'(`RW_MGR_REG_RAM_BASE + 4 * idx);
  endfunction

  task automatic check_data(input rw_data_t got, input rw_data_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s response %b, expected %b", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  // Address and data channels of a write are accepted together
  task automatic check_write_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: wready %b, expected %b to match awready", $time, got, exp);
      $display(">>> FAIL");
      $fatal(1, "write ready mismatch");
    end
  endtask

  // New word enters word 0, everything moves up, old word 3 falls out
  task automatic model_scan(input rw_data_t word);
    model_cap = model_mem[NWORDS-1];
    for (int k = NWORDS - 1; k > 0; k--) begin
      model_mem[k] = model_mem[k-1];
    end
    model_mem[0] = word;
  endtask

  task automatic axil_write(input axil_addr_t addr, input rw_data_t data,
                            output axil_resp_t resp);
    int delay;
    delay = $urandom_range(0, 3);
    @(negedge int_clk);
    aw.addr  = addr;
    aw.valid = 1'b1;
    w.data   = data;
    w.valid  = 1'b1;
    // Ready sampled at the rising edge is the one that counts for the handshake
    do begin
      @(posedge int_clk);
      check_write_ready(ready_out.wready, ready_out.awready);
    end while (!ready_out.awready);
    @(negedge int_clk);
    aw.valid = 1'b0;
    w.valid  = 1'b0;
    repeat (delay) @(negedge int_clk);
    ready_in.bready = 1'b1;
    do begin
      @(posedge int_clk);
    end while (!b.valid);
    resp = b.resp;
    @(negedge int_clk);
    ready_in.bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output rw_data_t data,
                           output axil_resp_t resp);
    int delay;
    delay = $urandom_range(0, 3);
    @(negedge int_clk);
    ar.addr  = addr;
    ar.valid = 1'b1;
    do begin
      @(posedge int_clk);
    end while (!ready_out.arready);
    @(negedge int_clk);
    ar.valid = 1'b0;
    repeat (delay) @(negedge int_clk);
    ready_in.rready = 1'b1;
    do begin
      @(posedge int_clk);
    end while (!r.valid);
    data = r.data;
    resp = r.resp;
    @(negedge int_clk);
    ready_in.rready = 1'b0;
  endtask

  task automatic ram_write(input int idx, input rw_data_t data);
    axil_resp_t resp;
    axil_write(ram_addr(idx), data, resp);
    check_resp(resp, AXIL_RESP_OKAY, $sformatf("RAM write word %0d", idx));
    model_mem[idx] = data;
  endtask

  task automatic scan_write(input rw_data_t data);
    axil_resp_t resp;
    axil_write(`RW_MGR_REG_SCAN, data, resp);
    check_resp(resp, AXIL_RESP_OKAY, "scan write");
    model_scan(data);
  endtask

  task automatic read_ram_word(input int idx);
    rw_data_t   data;
    axil_resp_t resp;
    axil_read(ram_addr(idx), data, resp);
    check_resp(resp, AXIL_RESP_OKAY, $sformatf("RAM read word %0d", idx));
    check_data(data, model_mem[idx], $sformatf("RAM word %0d", idx));
  endtask

  task automatic read_scan_reg();
    rw_data_t   data;
    axil_resp_t resp;
    axil_read(`RW_MGR_REG_SCAN, data, resp);
    check_resp(resp, AXIL_RESP_OKAY, "scan register read");
    check_data(data, model_cap, "scan capture");
  endtask

  task automatic read_status();
    rw_data_t   data;
    axil_resp_t resp;
    axil_read(`RW_MGR_REG_STATUS, data, resp);
    check_resp(resp, AXIL_RESP_OKAY, "status read");
    check_data(data, '0, "status word");
  endtask

  task automatic read_all_words();
    for (int k = 0; k < NWORDS; k++) begin
      read_ram_word(k);
    end
  endtask

  // Watchdog, generous bound per transaction including a full scan
  initial begin
    #(NUM_TXNS * 100 * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in %0d cycles", NUM_TXNS * 100);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int          seed_dummy;
    int          idx;
    int          op;
    rw_data_t    data;
    axil_resp_t  resp;
    axil_addr_t  bad_addr [4];

    seed_dummy = $urandom(20);
    int_clk    = 1'b0;
    reset      = 1'b1;
    aw         = '0;
    w          = '0;
    ar         = '0;
    ready_in   = '0;
    model_cap  = '0;
    for (int k = 0; k < NWORDS; k++) begin
      model_mem[k] = '0;
    end
    bad_addr[0] = 8'h18;
    bad_addr[1] = 8'h40;
    bad_addr[2] = 8'hfc;
    bad_addr[3] = 8'h06;

    repeat (5) @(negedge int_clk);
    reset = 1'b0;

    // Everything is zero after reset
    read_all_words();
    read_scan_reg();

    // Random RAM writes, then a write pair to one address
    for (int i = 0; i < 12; i++) begin
      ram_write($urandom_range(0, NWORDS - 1), $urandom);
    end
    idx = $urandom_range(0, NWORDS - 1);
    ram_write(idx, $urandom);
    ram_write(idx, $urandom);
    read_all_words();

    // One scan, then capture and shifted contents
    scan_write($urandom);
    read_scan_reg();
    read_all_words();

    // Random mix of all operations
    for (int i = 0; i < N_RANDOM; i++) begin
      op   = $urandom_range(0, 3);
      idx  = $urandom_range(0, NWORDS - 1);
      data = $urandom;
      case (op)
        0: ram_write(idx, data);
        1: scan_write(data);
        2: read_ram_word(idx);
        default: read_scan_reg();
      endcase
    end

    // Unmapped offsets
    for (int k = 0; k < 4; k++) begin
      axil_write(bad_addr[k], $urandom, resp);
      check_resp(resp, AXIL_RESP_SLVERR, $sformatf("write to 0x%h", bad_addr[k]));
    end
    read_all_words();
    for (int k = 0; k < 4; k++) begin
      axil_read(bad_addr[k], data, resp);
      check_resp(resp, AXIL_RESP_SLVERR, $sformatf("read of 0x%h", bad_addr[k]));
      check_data(data, '0, $sformatf("read of 0x%h", bad_addr[k]));
    end

    // Status between and after scans
    read_status();
    scan_write($urandom);
    read_status();
    scan_write($urandom);
    read_status();
    read_scan_reg();

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- rw_mgr.f
+incdir+hw
hw/rw_mgr_data_pkg.sv
hw/rw_mgr_bus_pkg.sv
hw/rw_mgr_ram_csr.sv
hw/rw_mgr_scan_ctrl.sv
hw/rw_mgr_axil_slave.sv
hw/rw_mgr_top.sv
verif/rw_mgr_tb.sv

//--- Bender.yml
package:
  name: rw_mgr

sources:
  - include_dirs:
      - hw
    files:
      - hw/rw_mgr_data_pkg.sv
      - hw/rw_mgr_bus_pkg.sv
      - hw/rw_mgr_ram_csr.sv
      - hw/rw_mgr_scan_ctrl.sv
      - hw/rw_mgr_axil_slave.sv
      - hw/rw_mgr_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/rw_mgr_tb.sv
